// ==== hdl/warp_params.svh ====
`ifndef WARP_PARAMS_SVH
`define WARP_PARAMS_SVH

// fetch delivers full-width instructions only
// compressed forms decode as illegal
`define WARP_INST_W 32

// integer register file index
// x0..x31
`define WARP_REG_ADDR_W 5

// immediate carried at 32 bits
// extension to 64 bits is left to the backend
`define WARP_IMM_W 32

// instructions per fetch group
// one decoder slot each
`define WARP_SLOTS 2

`endif

// ==== hdl/warp_pkg.sv ====
`include "warp_params.svh"

package warp_pkg;

    // major opcodes, bits [6:2] of a full-width instruction
    typedef enum logic [4:0] {
        OPC_LOAD      = 5'b00000,
        OPC_OP_IMM    = 5'b00100,
        OPC_AUIPC     = 5'b00101,
        OPC_OP_IMM_32 = 5'b00110,
        OPC_OP        = 5'b01100,
        OPC_LUI       = 5'b01101,
        OPC_OP_32     = 5'b01110
    } opcode_e;

    // immediate layouts
    typedef enum logic [2:0] {
        IMM_NONE = 3'd0,
        IMM_I    = 3'd1,
        IMM_S    = 3'd2,
        IMM_B    = 3'd3,
        IMM_U    = 3'd4,
        IMM_J    = 3'd5
    } imm_fmt_e;

    // backend pipeline select, one bit per pipeline
    typedef enum logic [3:0] {
        PIPE_NONE   = 4'b0000,
        PIPE_XARITH = 4'b0001,
        PIPE_XLOGIC = 4'b0010
    } pipeline_e;

    typedef enum logic [1:0] {
        XARITH_OP_ADD = 2'b00,
        XARITH_OP_SLT = 2'b01
    } xarith_op_e;

    // and sits at zero so an idle logic unit reads as all-zero controls
    typedef enum logic [2:0] {
        XLOGIC_OP_AND = 3'b000,
        XLOGIC_OP_OR  = 3'b001,
        XLOGIC_OP_XOR = 3'b010,
        XLOGIC_OP_SHF = 3'b011
    } xlogic_op_e;

    typedef struct packed {
        logic       word;
        logic       unsigned_op;
        logic       sub;
        xarith_op_e opsel;
    } xarith_ctrl_t;

    typedef struct packed {
        logic       word;
        xlogic_op_e opsel;
    } xlogic_ctrl_t;

    // rs1 in the low bits, rd on top
    typedef struct packed {
        logic [`WARP_REG_ADDR_W-1:0] rd;
        logic [`WARP_REG_ADDR_W-1:0] rs2;
        logic [`WARP_REG_ADDR_W-1:0] rs1;
    } raddr_t;

    // listed top down, so legal lands at bit 0
    typedef struct packed {
        xlogic_ctrl_t           xlogic;
        xarith_ctrl_t           xarith;
        logic                   op2_sel;
        pipeline_e              pipeline;
        logic [`WARP_IMM_W-1:0] imm;
        raddr_t                 raddr;
        logic                   legal;
    } bundle_t;

    // slot 0 in the low half
    typedef struct packed {
        bundle_t slot1;
        bundle_t slot0;
    } bundle_pair_t;

endpackage

// ==== hdl/warp_imm_gen.sv ====
`timescale 1ns/1ps

`include "warp_params.svh"

module warp_imm_gen
    import warp_pkg::*;
(
    input  logic [`WARP_INST_W-1:0] i_inst,
    input  imm_fmt_e                i_fmt,
    output logic [`WARP_IMM_W-1:0]  o_imm
);

    // sign bit of every format
    logic sign;

    assign sign = i_inst[31];

    always_comb begin
        case (i_fmt)
            // 12-bit field in [31:20]
            IMM_I: o_imm = {{(`WARP_IMM_W-12){sign}}, i_inst[31:20]};
            // split field, rd position holds the low bits
            IMM_S: o_imm = {{(`WARP_IMM_W-12){sign}}, i_inst[31:25], i_inst[11:7]};
            // branch offset
            // bit 11 sits in inst[7], bit 0 always zero
            IMM_B: begin
                o_imm = {{(`WARP_IMM_W-13){sign}}, i_inst[31], i_inst[7],
                         i_inst[30:25], i_inst[11:8], 1'b0};
            end
            // upper 20 bits, low 12 cleared
            IMM_U: o_imm = {{(`WARP_IMM_W-32){sign}}, i_inst[31:12], 12'h000};
            // jump offset
            // scrambled order, bit 0 always zero
            IMM_J: begin
                o_imm = {{(`WARP_IMM_W-21){sign}}, i_inst[31], i_inst[19:12],
                         i_inst[20], i_inst[30:21], 1'b0};
            end
            // r-type and anything unknown
            default: o_imm = '0;
        endcase
    end

endmodule

// ==== hdl/warp_udecode.sv ====
`timescale 1ns/1ps

`include "warp_params.svh"

module warp_udecode
    import warp_pkg::*;
(
    input  logic [`WARP_INST_W-1:0] i_inst,
    output bundle_t                 o_bundle
);

    // fixed instruction fields
    logic [4:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       full_width;
    raddr_t     raddr;

    assign opcode = i_inst[6:2];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];
    // anything other than 2'b11 here is a compressed encoding
    assign full_width = i_inst[1:0] == 2'b11;

    // register addresses always come from the fixed positions
    assign raddr.rs1 = i_inst[19:15];
    assign raddr.rs2 = i_inst[24:20];
    assign raddr.rd  = i_inst[11:7];

    // opcode classes
    logic imm_form;
    logic word_form;

    assign imm_form  = opcode == OPC_OP_IMM || opcode == OPC_OP_IMM_32;
    assign word_form = opcode == OPC_OP_IMM_32 || opcode == OPC_OP_32;

    // funct7 patterns
    logic f7_zero;
    logic f7_alt;
    logic sh64_ok;

    assign f7_zero = funct7 == 7'b0000000;
    assign f7_alt  = funct7 == 7'b0100000;
    // rv64 shamt uses bit 25, so only the upper six bits are checked
    assign sh64_ok = funct7[6:1] == 6'b000000 || funct7[6:1] == 6'b010000;

    // unit and operation from funct3
    // same map for immediate, register and word forms
    logic       use_arith;
    xarith_op_e arith_op;
    xlogic_op_e logic_op;

    always_comb begin
        use_arith = 1'b0;
        arith_op  = XARITH_OP_ADD;
        logic_op  = XLOGIC_OP_AND;
        case (funct3)
            3'b000: use_arith = 1'b1;
            3'b010, 3'b011: begin
                use_arith = 1'b1;
                arith_op  = XARITH_OP_SLT;
            end
            3'b001, 3'b101: logic_op = XLOGIC_OP_SHF;
            3'b100: logic_op = XLOGIC_OP_XOR;
            3'b110: logic_op = XLOGIC_OP_OR;
            default: logic_op = XLOGIC_OP_AND;
        endcase
    end

    // legality per opcode and funct3
    logic legal;

    always_comb begin
        legal = 1'b0;
        if (full_width) begin
            case (opcode)
                OPC_OP_IMM: begin
                    case (funct3)
                        3'b001: legal = funct7[6:1] == 6'b000000;
                        3'b101: legal = sh64_ok;
                        default: legal = 1'b1;
                    endcase
                end
                OPC_OP_IMM_32: begin
                    case (funct3)
                        3'b000: legal = 1'b1;
                        3'b001: legal = f7_zero;
                        3'b101: legal = f7_zero || f7_alt;
                        default: legal = 1'b0;
                    endcase
                end
                // slt, xor, or, and carry no funct7 check
                OPC_OP: begin
                    case (funct3)
                        3'b000, 3'b101: legal = f7_zero || f7_alt;
                        3'b001: legal = f7_zero;
                        default: legal = 1'b1;
                    endcase
                end
                OPC_OP_32: begin
                    case (funct3)
                        3'b000, 3'b101: legal = f7_zero || f7_alt;
                        3'b001: legal = f7_zero;
                        default: legal = 1'b0;
                    endcase
                end
                OPC_LUI, OPC_AUIPC: legal = 1'b1;
                default: legal = 1'b0;
            endcase
        end
    end

    // bundle control fields
    imm_fmt_e     imm_fmt;
    pipeline_e    pipeline;
    logic         op2_sel;
    xarith_ctrl_t xarith;
    xlogic_ctrl_t xlogic;

    always_comb begin
        imm_fmt  = IMM_NONE;
        pipeline = PIPE_NONE;
        op2_sel  = 1'b0;
        xarith   = '0;
        xlogic   = '0;
        case (opcode)
            OPC_OP_IMM, OPC_OP_IMM_32, OPC_OP, OPC_OP_32: begin
                imm_fmt      = imm_form ? IMM_I : IMM_NONE;
                pipeline     = use_arith ? PIPE_XARITH : PIPE_XLOGIC;
                op2_sel      = imm_form;
                xarith.opsel = arith_op;
                // funct7[5] picks sub and sra on the register forms
                xarith.sub   = !imm_form && funct7[5];
                // sltu and sltiu, 64-bit forms only
                xarith.unsigned_op = !word_form && funct3[0];
                xarith.word  = word_form;
                xlogic.opsel = logic_op;
                xlogic.word  = word_form;
            end
            // lui adds to x0, auipc to pc
            OPC_LUI, OPC_AUIPC: begin
                imm_fmt  = IMM_U;
                pipeline = PIPE_XARITH;
                op2_sel  = 1'b1;
            end
            default: pipeline = PIPE_NONE;
        endcase

        // illegal slots carry no controls and no immediate
        if (!legal) begin
            imm_fmt  = IMM_NONE;
            pipeline = PIPE_NONE;
            op2_sel  = 1'b0;
            xarith   = '0;
            xlogic   = '0;
        end
    end

    logic [`WARP_IMM_W-1:0] imm;

    warp_imm_gen u_imm_gen (
        .i_inst (i_inst),
        .i_fmt  (imm_fmt),
        .o_imm  (imm)
    );

    assign o_bundle = '{
        xlogic:   xlogic,
        xarith:   xarith,
        op2_sel:  op2_sel,
        pipeline: pipeline,
        imm:      imm,
        raddr:    raddr,
        legal:    legal
    };

endmodule

// ==== hdl/warp_skid.sv ====
`timescale 1ns/1ps

module warp_skid #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_input_valid,
    output logic     o_input_ready,
    input  payload_t i_input_data,
    output logic     o_output_valid,
    input  logic     i_output_ready,
    output payload_t o_output_data
);

    // output entry and skid entry
    logic     out_valid;
    logic     skid_valid;
    payload_t out_data;
    payload_t skid_data;

    logic in_fire;
    logic out_load;

    // ready comes straight from the skid flop
    assign o_input_ready = !skid_valid;
    assign in_fire       = i_input_valid && o_input_ready;
    // output entry empty or being taken this cycle
    assign out_load      = !out_valid || i_output_ready;

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_load) begin
            // skid drains first, no new pair can arrive while it is full
            if (skid_valid) begin
                out_valid  <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                out_valid <= in_fire;
            end
        end else if (in_fire) begin
            // output stalled, park the pair
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (out_load) begin
            out_data <= skid_valid ? skid_data : i_input_data;
        end
        if (in_fire && !out_load) begin
            skid_data <= i_input_data;
        end
    end

    assign o_output_valid = out_valid;
    assign o_output_data  = out_data;

endmodule

// ==== hdl/warp_decode.sv ====
`timescale 1ns/1ps

`include "warp_params.svh"

module warp_decode
    import warp_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    // fetch side
    output logic                    o_input_ready,
    input  logic                    i_input_valid,
    input  logic [`WARP_INST_W-1:0] i_inst0,
    input  logic [`WARP_INST_W-1:0] i_inst1,
    // issue side
    input  logic                    i_output_ready,
    output logic                    o_output_valid,
    output bundle_t                 o_bundle0,
    output bundle_t                 o_bundle1
);

    // per-slot instruction and decoded bundle
    logic [`WARP_INST_W-1:0] slot_inst   [`WARP_SLOTS];
    bundle_t                 slot_bundle [`WARP_SLOTS];

    assign slot_inst[0] = i_inst0;
    assign slot_inst[1] = i_inst1;

    // both slots decode in the same cycle
    for (genvar s = 0; s < `WARP_SLOTS; s++) begin : g_slot
        warp_udecode u_udecode (
            .i_inst   (slot_inst[s]),
            .o_bundle (slot_bundle[s])
        );
    end

    // pair travels through the buffer as one payload
    bundle_pair_t skid_in;
    bundle_pair_t skid_out;

    assign skid_in.slot0 = slot_bundle[0];
    assign skid_in.slot1 = slot_bundle[1];

    // holds decoded pairs while issue stalls
    // one cycle from accepted input to valid output
    warp_skid #(
        .payload_t (bundle_pair_t)
    ) u_skid (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_input_valid  (i_input_valid),
        .o_input_ready  (o_input_ready),
        .i_input_data   (skid_in),
        .o_output_valid (o_output_valid),
        .i_output_ready (i_output_ready),
        .o_output_data  (skid_out)
    );

    assign o_bundle0 = skid_out.slot0;
    assign o_bundle1 = skid_out.slot1;

endmodule

// ==== test/warp_tb_clk.sv ====
`timescale 1ns/1ps

module warp_tb_clk #(
    parameter int HALF_PERIOD  = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic o_clk,
    output logic o_rst_n
);

    // 40 ns period
    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // reset is active high despite the name
    initial begin
        o_rst_n <= 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst_n <= 1'b0;
    end

endmodule

// ==== test/warp_decode_checker.sv ====
`timescale 1ns/1ps

module warp_decode_checker
    import warp_pkg::*;
(
    input logic    i_clk,
    input logic    i_rst_n,
    input logic    o_input_ready,
    input logic    i_output_ready,
    input logic    o_output_valid,
    input bundle_t o_bundle0,
    input bundle_t o_bundle1
);

    // stalled pair stays put until issue takes it
    assert property (@(posedge i_clk) disable iff (i_rst_n)
        o_output_valid && !i_output_ready |=>
            o_output_valid && $stable(o_bundle0) && $stable(o_bundle1))
    else $error("output pair changed or dropped while stalled");

    // any reset edge empties both entries
    assert property (@(posedge i_clk) i_rst_n |=> !o_output_valid && o_input_ready)
    else $error("handshake outputs not at their reset values");

    // full skid moves into the output entry once the output drains
    assert property (@(posedge i_clk) disable iff (i_rst_n)
        !o_input_ready && o_output_valid && i_output_ready |=> o_input_ready)
    else $error("input ready still low after the output entry drained");

endmodule

bind warp_decode warp_decode_checker u_checker (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .o_input_ready  (o_input_ready),
    .i_output_ready (i_output_ready),
    .o_output_valid (o_output_valid),
    .o_bundle0      (o_bundle0),
    .o_bundle1      (o_bundle1)
);

// ==== test/warp_decode_tb.sv ====
`timescale 1ns/1ps

`include "warp_params.svh"

module warp_decode_tb
    import warp_pkg::*;
();

    localparam int          TABLE_LEN = 12;
    localparam logic [31:0] LFSR_SEED = 32'h6ced;
    // full 7-bit opcodes
    localparam logic [6:0]  OP_R      = 7'h33;
    localparam logic [6:0]  OP_R32    = 7'h3b;
    localparam logic [6:0]  OP_I      = 7'h13;
    localparam logic [6:0]  OP_I32    = 7'h1b;

    logic                    i_clk;
    logic                    i_rst_n;
    logic                    i_input_valid;
    logic                    o_input_ready;
    logic [`WARP_INST_W-1:0] i_inst0;
    logic [`WARP_INST_W-1:0] i_inst1;
    logic                    i_output_ready;
    logic                    o_output_valid;
    bundle_t                 o_bundle0;
    bundle_t                 o_bundle1;

    warp_tb_clk u_clk (
        .o_clk   (i_clk),
        .o_rst_n (i_rst_n)
    );

    warp_decode i_warp_decode (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .o_input_ready  (o_input_ready),
        .i_input_valid  (i_input_valid),
        .i_inst0        (i_inst0),
        .i_inst1        (i_inst1),
        .i_output_ready (i_output_ready),
        .o_output_valid (o_output_valid),
        .o_bundle0      (o_bundle0),
        .o_bundle1      (o_bundle1)
    );

    // row r uses entries 2r and 2r+1
    logic [`WARP_INST_W-1:0] tbl_inst [2*TABLE_LEN];
    bundle_t                 tbl_exp  [2*TABLE_LEN];
    int                      tbl_fill = 0;
    // pairs in flight and the cycle each was accepted
    bundle_pair_t            exp_q [$];
    int                      acc_q [$];
    int                      errors = 0;
    int                      checks = 0;
    int                      pairs_seen = 0;
    int                      cycle = 0;
    logic                    random_mode;
    logic                    check_latency;
    logic                    gap;
    logic [31:0]             lfsr = LFSR_SEED;
    logic                    held_valid = 1'b0;
    bundle_pair_t            held;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        // fibonacci, taps 32 22 2 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // register fields always show, everything else zero
    function automatic bundle_t base_bundle(input logic [31:0] inst);
        bundle_t b;
        b           = '0;
        b.raddr.rs1 = inst[19:15];
        b.raddr.rs2 = inst[24:20];
        b.raddr.rd  = inst[11:7];
        return b;
    endfunction

    function automatic bundle_t alu_bundle(input logic [31:0] inst, input pipeline_e pipe,
                                           input xarith_op_e aop, input xlogic_op_e lop);
        bundle_t b;
        logic    imm_form;
        logic    word;
        b                    = base_bundle(inst);
        imm_form             = inst[6:0] == OP_I || inst[6:0] == OP_I32;
        word                 = inst[6:0] == OP_R32 || inst[6:0] == OP_I32;
        b.legal              = 1'b1;
        b.pipeline           = pipe;
        b.op2_sel            = imm_form;
        b.xarith.opsel       = aop;
        // funct7 bit 5 on register forms
        b.xarith.sub         = !imm_form && inst[30];
        // funct3 bit 0, never on word forms
        b.xarith.unsigned_op = !word && inst[12];
        b.xarith.word        = word;
        b.xlogic.opsel       = lop;
        b.xlogic.word        = word;
        return b;
    endfunction

    task automatic add_entry(input logic [31:0] inst, input bundle_t exp);
        tbl_inst[tbl_fill] = inst;
        tbl_exp[tbl_fill]  = exp;
        tbl_fill++;
    endtask

    task automatic add_reg(input logic [31:0] inst, input pipeline_e pipe,
                           input xarith_op_e aop, input xlogic_op_e lop);
        add_entry(inst, alu_bundle(inst, pipe, aop, lop));
    endtask

    task automatic add_imm(input logic [31:0] inst, input pipeline_e pipe,
                           input xarith_op_e aop, input xlogic_op_e lop,
                           input logic [31:0] imm);
        bundle_t b;
        b     = alu_bundle(inst, pipe, aop, lop);
        b.imm = imm;
        add_entry(inst, b);
    endtask

    // lui and auipc, adder with the immediate and no other controls
    task automatic add_upper(input logic [31:0] inst, input logic [31:0] imm);
        bundle_t b;
        b          = base_bundle(inst);
        b.legal    = 1'b1;
        b.pipeline = PIPE_XARITH;
        b.op2_sel  = 1'b1;
        b.imm      = imm;
        add_entry(inst, b);
    endtask

    // only the register fields survive an illegal decode
    task automatic add_illegal(input logic [31:0] inst);
        add_entry(inst, base_bundle(inst));
    endtask

    task automatic build_table();
        add_reg(enc_r(7'h00, 3, 2, 3'd0, 1, OP_R), PIPE_XARITH, XARITH_OP_ADD, XLOGIC_OP_AND);
        add_reg(enc_r(7'h20, 6, 5, 3'd0, 4, OP_R), PIPE_XARITH, XARITH_OP_ADD, XLOGIC_OP_AND);
        add_reg(enc_r(7'h00, 9, 8, 3'd2, 7, OP_R), PIPE_XARITH, XARITH_OP_SLT, XLOGIC_OP_AND);
        add_reg(enc_r(7'h00, 12, 11, 3'd3, 10, OP_R), PIPE_XARITH, XARITH_OP_SLT, XLOGIC_OP_AND);
        add_reg(enc_r(7'h00, 15, 14, 3'd7, 13, OP_R), PIPE_XLOGIC, XARITH_OP_ADD, XLOGIC_OP_AND);
        add_reg(enc_r(7'h00, 18, 17, 3'd6, 16, OP_R), PIPE_XLOGIC, XARITH_OP_ADD, XLOGIC_OP_OR);
        add_reg(enc_r(7'h00, 21, 20, 3'd4, 19, OP_R), PIPE_XLOGIC, XARITH_OP_ADD, XLOGIC_OP_XOR);
        add_reg(enc_r(7'h00, 24, 23, 3'd1, 22, OP_R), PIPE_XLOGIC, XARITH_OP_ADD, XLOGIC_OP_SHF);
        add_reg(enc_r(7'h00, 27, 26, 3'd5, 25, OP_R), PIPE_XLOGIC, XARITH_OP_ADD, XLOGIC_OP_SHF);
        add_reg(enc_r(7'h20, 30, 29, 3'd5, 28, OP_R), PIPE_XLOGIC, XARITH_OP_ADD, XLOGIC_OP_SHF);
        // addw subw sllw sraw
        add_reg(enc_r(7'h00, 3, 2, 3'd0, 1, OP_R32), PIPE_XARITH, XARITH_OP_ADD, XLOGIC_OP_AND);
        add_reg(enc_r(7'h20, 5, 4, 3'd0, 3, OP_R32), PIPE_XARITH, XARITH_OP_ADD, XLOGIC_OP_AND);
        add_reg(enc_r(7'h00, 8, 7, 3'd1, 6, OP_R32), PIPE_XLOGIC, XARITH_OP_ADD, XLOGIC_OP_SHF);
        add_reg(enc_r(7'h20, 11, 10, 3'd5, 9, OP_R32), PIPE_XLOGIC, XARITH_OP_ADD, XLOGIC_OP_SHF);
        // addi -5, slti 100, slli 3, srai 33, addiw -1
        add_imm(enc_i(12'hffb, 6, 3'd0, 5, OP_I), PIPE_XARITH, XARITH_OP_ADD, XLOGIC_OP_AND,
                32'hffff_fffb);
        add_imm(enc_i(12'd100, 8, 3'd2, 7, OP_I), PIPE_XARITH, XARITH_OP_SLT, XLOGIC_OP_AND,
                32'd100);
        add_imm(enc_i(12'h003, 2, 3'd1, 1, OP_I), PIPE_XLOGIC, XARITH_OP_ADD, XLOGIC_OP_SHF,
                32'd3);
        add_imm(enc_i(12'h421, 4, 3'd5, 3, OP_I), PIPE_XLOGIC, XARITH_OP_ADD, XLOGIC_OP_SHF,
                32'h421);
        add_imm(enc_i(12'hfff, 11, 3'd0, 10, OP_I32), PIPE_XARITH, XARITH_OP_ADD, XLOGIC_OP_AND,
                32'hffff_ffff);
        // lui x12 0x80001, auipc x13 0x12345
        add_upper(32'h8000_1637, 32'h8000_1000);
        add_upper(32'h1234_5697, 32'h1234_5000);
        // load, slli with funct7 0000010, add with funct7 0000001
        add_illegal(enc_i(12'd8, 2, 3'd2, 1, 7'h03));
        add_illegal(enc_r(7'h02, 3, 2, 3'd1, 1, OP_I));
        add_illegal(enc_r(7'h01, 3, 2, 3'd0, 1, OP_R));
    endtask

    task automatic check_bundle(input string name, input bundle_t got, input bundle_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at time %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at time %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_idle();
        check_flag("o_output_valid", o_output_valid, 1'b0);
        check_flag("o_input_ready", o_input_ready, 1'b1);
    endtask

    task automatic report_test(input string name, input int mark);
        if (errors == mark)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - mark);
    endtask

    task automatic send_table(input logic stream);
        bundle_pair_t exp;
        for (int r = 0; r < TABLE_LEN; r++) begin
            while (gap) begin
                i_input_valid <= 1'b0;
                @(posedge i_clk);
            end
            i_input_valid <= 1'b1;
            i_inst0       <= tbl_inst[2*r];
            i_inst1       <= tbl_inst[2*r+1];
            @(posedge i_clk);
            // no back-pressure, so every edge should take a pair
            if (stream) check_flag("o_input_ready", o_input_ready, 1'b1);
            while (!o_input_ready) @(posedge i_clk);
            exp.slot0 = tbl_exp[2*r];
            exp.slot1 = tbl_exp[2*r+1];
            exp_q.push_back(exp);
            acc_q.push_back(cycle);
        end
        i_input_valid <= 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) @(posedge i_clk);
        @(posedge i_clk);
    endtask

    always @(posedge i_clk) cycle <= cycle + 1;

    // ready and gap bits from the lfsr
    initial begin
        i_output_ready <= 1'b1;
        gap            <= 1'b0;
        forever begin
            @(posedge i_clk);
            if (random_mode) begin
                lfsr = lfsr_step(lfsr);
                i_output_ready <= lfsr[0];
                lfsr = lfsr_step(lfsr);
                gap <= lfsr[0];
            end else begin
                i_output_ready <= 1'b1;
                gap            <= 1'b0;
            end
        end
    end

    // collector, values sampled at the edge they transfer on
    initial begin
        bundle_pair_t exp;
        int           acc;
        forever begin
            @(posedge i_clk);
            if (!i_rst_n) begin
                if (held_valid) begin
                    check_flag("o_output_valid", o_output_valid, 1'b1);
                    check_bundle("o_bundle0", o_bundle0, held.slot0);
                    check_bundle("o_bundle1", o_bundle1, held.slot1);
                end
                held_valid = o_output_valid && !i_output_ready;
                held.slot0 = o_bundle0;
                held.slot1 = o_bundle1;
                if (o_output_valid && i_output_ready) begin
                    // every pair that leaves counts, expected or not
                    pairs_seen++;
                    if (exp_q.size() == 0) begin
                        errors++;
                        $display("a pair left at time %0t with none outstanding", $time);
                    end else begin
                        exp = exp_q.pop_front();
                        acc = acc_q.pop_front();
                        check_bundle("o_bundle0", o_bundle0, exp.slot0);
                        check_bundle("o_bundle1", o_bundle1, exp.slot1);
                        if (check_latency && cycle != acc + 1) begin
                            errors++;
                            $display("pair taken in cycle %0d left in cycle %0d, not one later",
                                     acc, cycle);
                        end
                    end
                end
            end
        end
    end

    initial begin
        repeat (TABLE_LEN * 20) @(posedge i_clk);
        $display("timeout after %0d cycles, run did not finish", TABLE_LEN * 20);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int mark;
        i_input_valid <= 1'b0;
        i_inst0       <= '0;
        i_inst1       <= '0;
        random_mode   <= 1'b0;
        check_latency <= 1'b1;
        build_table();
        mark = errors;
        @(posedge i_clk);
        while (i_rst_n) begin
            @(negedge i_clk);
            check_idle();
            @(posedge i_clk);
        end
        // first cycle out of reset
        @(negedge i_clk);
        check_idle();
        @(posedge i_clk);
        report_test("reset values", mark);
        mark = errors;
        send_table(1'b1);
        drain();
        report_test("streaming decode", mark);
        mark = errors;
        random_mode   <= 1'b1;
        check_latency <= 1'b0;
        send_table(1'b0);
        drain();
        if (pairs_seen != 2 * TABLE_LEN) begin
            errors++;
            $display("expected %0d pairs in total, saw %0d", 2 * TABLE_LEN, pairs_seen);
        end
        report_test("random back-pressure", mark);
        $display("checks %0d, errors %0d, pairs %0d", checks, errors, pairs_seen);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// ==== warp_decode.f ====
+incdir+hdl
hdl/warp_pkg.sv
hdl/warp_imm_gen.sv
hdl/warp_udecode.sv
hdl/warp_skid.sv
hdl/warp_decode.sv
test/warp_tb_clk.sv
test/warp_decode_checker.sv
test/warp_decode_tb.sv
